//--- hdl/encoderPkg.sv
package encoderPkg;

  // width of one position count, the counter wraps at this size
  localparam int CountWidth = 16;

  // number of encoder channels handled by the top level
  localparam int NumChannels = 2;

  // depth of the pin synchronizer in front of each decoder
  localparam int SyncStages = 2;

  // one A/B pin pair of an encoder
  // b sits above a so that the packed value reads as the B,A sample
  typedef struct packed {
    logic b;
    logic a;
  } quadPins;

  // Gray-code phase of the pins, named by the B,A sample
  // forward motion walks 00, 01, 11, 10 and back to 00, so A leads B
  typedef enum logic [1:0] {
    phase00 = 2'b00,
    phase01 = 2'b01,
    phase11 = 2'b11,
    phase10 = 2'b10
  } quadPhase;

  // event pulse from a decoder, high for one cycle
  // up is only meaningful while step is high
  // illegal marks a jump of two phases within one sample
  typedef struct packed {
    logic step;
    logic up;
    logic illegal;
  } stepEvent;

  // signed position, two's complement wrap on overflow
  typedef logic signed [CountWidth-1:0] countValue;

endpackage

//--- hdl/faultLatch.sv
`timescale 1ns/1ps

module faultLatch (
  input  logic                              clk,
  input  logic                              resetn,
  input  logic [encoderPkg::NumChannels-1:0] illegal,
  input  logic                              clearFault,
  output logic                              faultn
);

  // one sticky flag per channel
  logic [encoderPkg::NumChannels-1:0] faultFlag;

  // clear mask, all ones while the clear strobe is high
  logic [encoderPkg::NumChannels-1:0] clearMask;

  assign clearMask = {encoderPkg::NumChannels{clearFault}};

  // flags are set by an illegal pulse and held until the clear strobe
  // the set term is or-ed in after the clear, so a fault in the same
  // cycle as the clear still lands in the flag
  always_ff @(posedge clk) begin
    if (!resetn) begin
      faultFlag <= '0;
    end else begin
      faultFlag <= (faultFlag & ~clearMask) | illegal;
    end
  end

  // faultn drops as soon as any channel has a flag set
  // the flags are registered, so this is one cycle after the pulse
  assign faultn = ~|faultFlag;

  // a fresh reset always leaves the fault output released
  noFaultAfterReset: assert property (
    @(posedge clk)
    resetn && !$past(resetn) |-> faultn
  );

endmodule

//--- hdl/pinSync.sv
`timescale 1ns/1ps

module pinSync (
  input  logic                clk,
  input  logic                resetn,
  input  encoderPkg::quadPins pins,
  output encoderPkg::quadPins syncPins
);

  // shift register of pin pairs, stage 0 is the one that may go metastable
  encoderPkg::quadPins syncStage [encoderPkg::SyncStages];

  // the pins come straight from the encoder connector and have no relation
  // to clk, so both bits are moved through the same chain of flops
  // a and b travel together so they stay aligned to the same sample
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < encoderPkg::SyncStages; i++) begin
        syncStage[i] <= '0;
      end
    end else begin
      syncStage[0] <= pins;
      // each later stage takes the value of the stage before it
      for (int i = 1; i < encoderPkg::SyncStages; i++) begin
        syncStage[i] <= syncStage[i-1];
      end
    end
  end

  // the last stage is safe to use in the clock domain
  // with two stages a pin change shows up two edges after it is sampled
  assign syncPins = syncStage[encoderPkg::SyncStages-1];

endmodule

//--- hdl/positionCounter.sv
`timescale 1ns/1ps

module positionCounter (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  step,
  input  logic                  up,
  output encoderPkg::countValue count
);

  // signed one, so the add stays in the signed domain of the count
  localparam encoderPkg::countValue StepOne = encoderPkg::countValue'(1);

  // the count moves by one per step pulse
  // overflow past the top or bottom simply wraps in two's complement,
  // which keeps the position valid modulo 2^CountWidth
  always_ff @(posedge clk) begin
    if (!resetn) begin
      count <= '0;
    end else if (step) begin
      if (up) begin
        count <= count + StepOne;
      end else begin
        count <= count - StepOne;
      end
    end
  end

  // without a step pulse the position must not drift
  countHolds: assert property (
    @(posedge clk) disable iff (!resetn)
    !step |=> $stable(count)
  );

endmodule

//--- hdl/quadDecoder.sv
`timescale 1ns/1ps

module quadDecoder (
  input  logic                 clk,
  input  logic                 resetn,
  input  encoderPkg::quadPins  syncPins,
  output encoderPkg::stepEvent evt
);

  // phase the decoder last saw on the pins
  encoderPkg::quadPhase phase;

  // phase of the current synchronized sample
  encoderPkg::quadPhase newPhase;

  // set by reset and shifted down one bit per cycle
  // while bit 0 is set a sample only loads the phase, which covers the
  // synchronizer stages that still hold their reset value
  logic [encoderPkg::SyncStages:0] firstSample;

  // event decoded from this sample, registered into evt
  encoderPkg::stepEvent nextEvt;

  // phase that follows p when the shaft turns forward
  function automatic encoderPkg::quadPhase fwdPhase(input encoderPkg::quadPhase p);
    case (p)
      encoderPkg::phase00: fwdPhase = encoderPkg::phase01;
      encoderPkg::phase01: fwdPhase = encoderPkg::phase11;
      encoderPkg::phase11: fwdPhase = encoderPkg::phase10;
      encoderPkg::phase10: fwdPhase = encoderPkg::phase00;
      default:             fwdPhase = encoderPkg::phase00;
    endcase
  endfunction

  // phase that follows p when the shaft turns backward
  function automatic encoderPkg::quadPhase backPhase(input encoderPkg::quadPhase p);
    case (p)
      encoderPkg::phase00: backPhase = encoderPkg::phase10;
      encoderPkg::phase10: backPhase = encoderPkg::phase11;
      encoderPkg::phase11: backPhase = encoderPkg::phase01;
      encoderPkg::phase01: backPhase = encoderPkg::phase00;
      default:             backPhase = encoderPkg::phase00;
    endcase
  endfunction

  // the sample is read as B,A to match the phase names
  assign newPhase = encoderPkg::quadPhase'({syncPins.b, syncPins.a});

  // compare the new sample with the stored phase
  // only one pin may move per sample, so the four cases are exclusive
  always_comb begin
    nextEvt = '0;
    if (newPhase == fwdPhase(phase)) begin
      nextEvt.step = 1'b1;
      nextEvt.up   = 1'b1;
    end else if (newPhase == backPhase(phase)) begin
      nextEvt.step = 1'b1;
      nextEvt.up   = 1'b0;
    end else if (newPhase != phase) begin
      // both pins moved together, the direction is unknown
      nextEvt.illegal = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      phase       <= encoderPkg::phase00;
      firstSample <= '1;
      evt         <= '0;
    end else if (firstSample[0]) begin
      // the pins may sit in any phase at reset, so the samples that follow
      // reset are taken as the starting point and give no event
      phase       <= newPhase;
      firstSample <= firstSample >> 1;
      evt         <= '0;
    end else begin
      // the phase always follows the pins, an illegal jump resyncs it
      phase <= newPhase;
      evt   <= nextEvt;
    end
  end

  // a sample is either a step or a fault, never both
  stepOrIllegal: assert property (
    @(posedge clk) disable iff (!resetn)
    !(evt.step && evt.illegal)
  );

  // coming out of reset nothing may reach the counter or the fault latch
  quietAfterReset: assert property (
    @(posedge clk)
    resetn && !$past(resetn) |-> evt == '0
  );

endmodule

//--- hdl/quadEncoderTop.sv
`timescale 1ns/1ps

module quadEncoderTop (
  input  logic                                          clk,
  input  logic                                          resetn,
  // raw encoder pins, asynchronous to clk
  input  encoderPkg::quadPins [encoderPkg::NumChannels-1:0] encPins,
  // one cycle strobe that releases the latched faults
  input  logic                                          clearFault,
  output encoderPkg::countValue                         count0,
  output encoderPkg::countValue                         count1,
  // low while any channel has seen an illegal transition
  output logic                                          faultn
);

  // per channel position, split out to the two count ports below
  encoderPkg::countValue counts [encoderPkg::NumChannels];

  // illegal bits of all channels, collected for the shared latch
  logic [encoderPkg::NumChannels-1:0] illegalBits;

  // every channel is the same chain of synchronizer, decoder and counter
  // the latency from a pin edge to the count is four clock edges
  for (genvar ch = 0; ch < encoderPkg::NumChannels; ch++) begin : channel

    // pins after the two flop synchronizer
    encoderPkg::quadPins syncPins;

    // one cycle step or fault pulse from the decoder
    encoderPkg::stepEvent evt;

    pinSync sync (
      .clk      (clk),
      .resetn   (resetn),
      .pins     (encPins[ch]),
      .syncPins (syncPins)
    );

    quadDecoder decoder (
      .clk      (clk),
      .resetn   (resetn),
      .syncPins (syncPins),
      .evt      (evt)
    );

    positionCounter counter (
      .clk    (clk),
      .resetn (resetn),
      .step   (evt.step),
      .up     (evt.up),
      .count  (counts[ch])
    );

    assign illegalBits[ch] = evt.illegal;

  end

  // one latch serves all channels and drives the single fault output
  faultLatch faults (
    .clk        (clk),
    .resetn     (resetn),
    .illegal    (illegalBits),
    .clearFault (clearFault),
    .faultn     (faultn)
  );

  assign count0 = counts[0];
  assign count1 = counts[1];

endmodule

//--- quadEncoderTop.f
hdl/encoderPkg.sv
hdl/pinSync.sv
hdl/quadDecoder.sv
hdl/positionCounter.sv
hdl/faultLatch.sv
hdl/quadEncoderTop.sv
test/quadEncoderTb.sv

//--- runSim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and decide the result from the log.

verilator --binary --timing --assert --top-module quadEncoderTb \
  -Mdir obj_dir -o simv -f quadEncoderTop.f > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/simv > sim.log 2>&1

grep -qx "Testbench passed" sim.log \
  && echo "simulation result: PASS" \
  || { echo "simulation result: FAIL, see sim.log"; exit 1; }

//--- test/quadEncoderTb.sv
`timescale 1ns/1ps

module quadEncoderTb;

  // every pin state is held this long, well past the 4 cycle pin to count latency
  localparam int HoldCycles = 8;

  // number of rows in the stimulus table
  localparam int NumEntries = 16;

  // extra cycles on top of the table length before the watchdog fires
  localparam int MarginCycles = 100;

  // what one table row does to the pins
  typedef enum logic [1:0] {
    modeForward,
    modeBackward,
    modeJump,
    modeClear
  } entryMode;

  // one row of the table
  // chSel 0 or 1 picks a channel, 2 moves both with channel 1 turning the other way
  // a step count of 0 is replaced by a random count before the run
  typedef struct packed {
    logic [1:0] chSel;
    int         steps;
    entryMode   mode;
  } stimEntry;

  logic                                                  clk;
  logic                                                  resetn;
  encoderPkg::quadPins [encoderPkg::NumChannels-1:0]     encPins;
  logic                                                  clearFault;
  encoderPkg::countValue                                 count0;
  encoderPkg::countValue                                 count1;
  logic                                                  faultn;

  // reference model of the counts and the sticky fault flags
  encoderPkg::countValue              expCount [encoderPkg::NumChannels];
  logic [encoderPkg::NumChannels-1:0] expFault;

  stimEntry stimTable [NumEntries];

  int seed = 32'h0246_79ae;
  int errorCount = 0;
  int checkCount = 0;
  int cycleCount = 0;
  int cycleLimit = 0;

  quadEncoderTop UUT (
    .clk        (clk),
    .resetn     (resetn),
    .encPins    (encPins),
    .clearFault (clearFault),
    .count0     (count0),
    .count1     (count1),
    .faultn     (faultn)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // watchdog, the limit is set from the table once the random counts are known
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("timeout reached after %0d cycles, the stimulus did not finish", cycleCount);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic stimEntry makeEntry(input logic [1:0] chSel, input int steps,
                                         input entryMode mode);
    stimEntry e;
    e.chSel = chSel;
    e.steps = steps;
    e.mode  = mode;
    return e;
  endfunction

  // move one channel by one phase along the Gray sequence 00, 01, 11, 10
  // the position in that sequence is {b, b^a}, so stepping is a plain add
  task automatic stepChannel(input int ch, input logic up);
    logic [1:0] cur;
    logic [1:0] idx;
    cur = encPins[ch];
    idx = {cur[1], cur[1] ^ cur[0]};
    if (up) begin
      idx = idx + 2'd1;
      expCount[ch] = expCount[ch] + 16'sd1;
    end else begin
      idx = idx - 2'd1;
      expCount[ch] = expCount[ch] - 16'sd1;
    end
    encPins[ch] = encoderPkg::quadPins'({idx[1], idx[1] ^ idx[0]});
  endtask

  // flip both pins at once, a two phase jump that must count nothing
  task automatic jumpChannel(input int ch);
    logic [1:0] cur;
    cur = encPins[ch];
    encPins[ch] = encoderPkg::quadPins'(~cur);
    expFault[ch] = 1'b1;
  endtask

  task automatic moveChannel(input int ch, input entryMode mode, input logic reverse);
    if (mode == modeJump) begin
      jumpChannel(ch);
    end else begin
      stepChannel(ch, (mode == modeForward) ^ reverse);
    end
  endtask

  // called right after a falling edge, returns on a falling edge
  task automatic applyEntry(input stimEntry e);
    if (e.mode == modeClear) begin
      clearFault = 1'b1;
      @(negedge clk);
      clearFault = 1'b0;
      expFault = '0;
      repeat (HoldCycles) @(negedge clk);
    end else begin
      for (int i = 0; i < e.steps; i++) begin
        if (e.chSel == 2'd0 || e.chSel == 2'd2) begin
          moveChannel(0, e.mode, 1'b0);
        end
        if (e.chSel == 2'd1 || e.chSel == 2'd2) begin
          moveChannel(1, e.mode, e.chSel == 2'd2);
        end
        repeat (HoldCycles) @(negedge clk);
      end
    end
  endtask

  task automatic checkOutputs(input int entry);
    checkCount++;
    assert (count0 === expCount[0]) else begin
      errorCount++;
      $display("[FAIL] %0t: entry %0d count0 is %0d, expected %0d",
               $time, entry, count0, expCount[0]);
    end
    assert (count1 === expCount[1]) else begin
      errorCount++;
      $display("[FAIL] %0t: entry %0d count1 is %0d, expected %0d",
               $time, entry, count1, expCount[1]);
    end
    assert (faultn === ~|expFault) else begin
      errorCount++;
      $display("[FAIL] %0t: entry %0d faultn is %b, expected %b",
               $time, entry, faultn, ~|expFault);
    end
  endtask

  initial begin
    int totalCycles;

    // the pins start away from the 00 reset value of the synchronizer,
    // channel 0 in phase 11 and channel 1 in phase 01
    resetn     = 1'b0;
    encPins[0] = encoderPkg::quadPins'(2'b11);
    encPins[1] = encoderPkg::quadPins'(2'b01);
    clearFault = 1'b0;
    expCount[0] = '0;
    expCount[1] = '0;
    expFault    = '0;

    stimTable[0]  = makeEntry(2'd0, 10, modeForward);
    stimTable[1]  = makeEntry(2'd0, 4, modeBackward);
    stimTable[2]  = makeEntry(2'd1, 0, modeForward);
    stimTable[3]  = makeEntry(2'd0, 0, modeForward);
    // at most 46 up at this point, so this goes negative
    stimTable[4]  = makeEntry(2'd0, 100, modeBackward);
    // a full turn of the 16 bit counter lands on the same value
    stimTable[5]  = makeEntry(2'd0, 65536, modeForward);
    stimTable[6]  = makeEntry(2'd1, 1, modeJump);
    stimTable[7]  = makeEntry(2'd1, 6, modeForward);
    stimTable[8]  = makeEntry(2'd1, 3, modeBackward);
    stimTable[9]  = makeEntry(2'd0, 1, modeClear);
    stimTable[10] = makeEntry(2'd2, 0, modeForward);
    stimTable[11] = makeEntry(2'd0, 1, modeJump);
    stimTable[12] = makeEntry(2'd2, 0, modeBackward);
    stimTable[13] = makeEntry(2'd0, 1, modeClear);
    stimTable[14] = makeEntry(2'd1, 0, modeBackward);
    stimTable[15] = makeEntry(2'd2, 30, modeForward);

    // resolve the random counts first so the run length is known
    totalCycles = 4 + HoldCycles;
    for (int i = 0; i < NumEntries; i++) begin
      if (stimTable[i].steps == 0) begin
        stimTable[i].steps = 1 + int'($unsigned($random(seed)) % 32'd40);
      end
      if (stimTable[i].mode == modeClear) begin
        totalCycles = totalCycles + 1 + HoldCycles;
      end else begin
        totalCycles = totalCycles + stimTable[i].steps * HoldCycles;
      end
    end
    cycleLimit = totalCycles + MarginCycles;

    repeat (4) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;

    // counts at zero and no fault once the decoder has taken its first sample
    repeat (HoldCycles) @(negedge clk);
    checkOutputs(-1);

    for (int i = 0; i < NumEntries; i++) begin
      applyEntry(stimTable[i]);
      checkOutputs(i);
    end

    $display("checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
